//--- src.f
hdl/c4_pkg.sv
hdl/drop_if.sv
hdl/button_sync.sv
hdl/game_control.sv
hdl/board_store.sv
hdl/win_checker.sv
hdl/connect_four.sv
dv/tb_connect_four.sv

//--- Bender.yml
package:
  name: connect_four

sources:
  - hdl/c4_pkg.sv
  - hdl/drop_if.sv
  - hdl/button_sync.sv
  - hdl/game_control.sv
  - hdl/board_store.sv
  - hdl/win_checker.sv
  - hdl/connect_four.sv
  - target: test
    files:
      - dv/tb_connect_four.sv

//--- dv/tb_connect_four.sv
`timescale 1ns/1ns
`default_nettype none

module tb_connect_four;

    import c4_pkg::*;

    localparam int ROWS = 8;
    localparam int COLS = 8;
    localparam int MAX_CYCLES = 6000;

    logic        clk;
    logic        rst_n;
    logic        move_right;
    logic        move_left;
    logic        drop_piece;
    cell_t       board_out [0:ROWS-1][0:COLS-1];
    logic [2:0]  current_col;
    cell_t       current_player;
    logic        game_over;
    cell_t       winner;

    // Reference model
    cell_t       m_board [0:ROWS-1][0:COLS-1];
    int          m_heights [0:COLS-1];
    int          m_col;
    cell_t       m_player;
    logic        m_over;
    cell_t       m_winner;

    logic        settle;
    logic [15:0] lfsr;
    int          errors;
    int          cycles;
    logic [2*ROWS*COLS-1:0] dut_flat;
    logic [2*ROWS*COLS-1:0] ref_flat;

    connect_four #(.ROWS(ROWS), .COLS(COLS)) i_dut
    (
        .clk            (clk),
        .rst_n          (rst_n),
        .move_right     (move_right),
        .move_left      (move_left),
        .drop_piece     (drop_piece),
        .board_out      (board_out),
        .current_col    (current_col),
        .current_player (current_player),
        .game_over      (game_over),
        .winner         (winner)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    always_comb
    begin
        for (int r = 0; r < ROWS; r++)
        begin
            for (int c = 0; c < COLS; c++)
            begin
                dut_flat[2*(r*COLS+c) +: 2] = board_out[r][c];
                ref_flat[2*(r*COLS+c) +: 2] = m_board[r][c];
            end
        end
    end

    task automatic mismatch(input string name, input logic [127:0] dut_val,
                            input logic [127:0] ref_val);
        errors++;
        $display("Mismatch at %0t: %s dut=%0h expected=%0h", $time, name, dut_val, ref_val);
    endtask

    a_board: assert property (@(posedge clk) disable iff (!rst_n)
        settle |-> dut_flat == ref_flat)
        else mismatch("board_out", $sampled(dut_flat), $sampled(ref_flat));
    a_col: assert property (@(posedge clk) disable iff (!rst_n)
        settle |-> current_col == m_col)
        else mismatch("current_col", $sampled(current_col), $sampled(m_col));
    a_player: assert property (@(posedge clk) disable iff (!rst_n)
        settle |-> current_player == m_player)
        else mismatch("current_player", $sampled(current_player), $sampled(m_player));
    a_over: assert property (@(posedge clk) disable iff (!rst_n)
        settle |-> game_over == m_over)
        else mismatch("game_over", $sampled(game_over), $sampled(m_over));
    a_winner: assert property (@(posedge clk) disable iff (!rst_n)
        settle |-> winner == m_winner)
        else mismatch("winner", $sampled(winner), $sampled(m_winner));

    // Four or more of p in a line through (r, c)
    function automatic logic four_through(input int r, input int c, input cell_t p);
        int dr [4] = '{0, 1, 1, 1};
        int dc [4] = '{1, 0, 1, -1};
        int run;
        int rr;
        int cc;
        four_through = 1'b0;
        for (int d = 0; d < 4; d++)
        begin
            run = 1;
            for (int s = -1; s <= 1; s += 2)
            begin
                rr = r + s * dr[d];
                cc = c + s * dc[d];
                while (rr >= 0 && rr < ROWS && cc >= 0 && cc < COLS && m_board[rr][cc] == p)
                begin
                    run++;
                    rr += s * dr[d];
                    cc += s * dc[d];
                end
            end
            if (run >= 4)
            begin
                four_through = 1'b1;
            end
        end
    endfunction

    task automatic model_press(input logic r, input logic l, input logic d);
        if (!m_over)
        begin
            if (r && !l)
            begin
                m_col = (m_col == COLS - 1) ? 0 : m_col + 1;
            end
            else if (l && !r)
            begin
                m_col = (m_col == 0) ? COLS - 1 : m_col - 1;
            end
            if (d && m_heights[m_col] < ROWS)
            begin
                m_board[m_heights[m_col]][m_col] = m_player;
                if (four_through(m_heights[m_col], m_col, m_player))
                begin
                    m_over   = 1'b1;
                    m_winner = m_player;
                end
                else
                begin
                    m_heights[m_col]++;
                    m_player = (m_player == PLAYER1) ? PLAYER2 : PLAYER1;
                end
            end
        end
    endtask

    // Button held low for 4 cycles, then time to settle before checks resume
    task automatic push(input logic r, input logic l, input logic d);
        settle = 1'b0;
        model_press(r, l, d);
        move_right = !r;
        move_left  = !l;
        drop_piece = !d;
        repeat (4) @(posedge clk);
        #2;
        move_right = 1'b1;
        move_left  = 1'b1;
        drop_piece = 1'b1;
        repeat (30) @(posedge clk);
        #2;
        settle = 1'b1;
        @(posedge clk);
        #2;
    endtask

    task automatic goto_col(input int col);
        while (m_col != col)
        begin
            push(1'b1, 1'b0, 1'b0);
        end
    endtask

    task automatic drop_at(input int col);
        goto_col(col);
        push(1'b0, 1'b0, 1'b1);
    endtask

    task automatic reset_dut();
        settle = 1'b0;
        rst_n  = 1'b0;
        for (int r = 0; r < ROWS; r++)
        begin
            for (int c = 0; c < COLS; c++)
            begin
                m_board[r][c] = EMPTY;
            end
        end
        for (int c = 0; c < COLS; c++)
        begin
            m_heights[c] = 0;
        end
        m_col    = 0;
        m_player = PLAYER1;
        m_over   = 1'b0;
        m_winner = EMPTY;
        repeat (8) @(posedge clk);
        #2;
        rst_n  = 1'b1;
        settle = 1'b1;
        repeat (2) @(posedge clk);
        #2;
    endtask

    task automatic random_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    endtask

    // The game must have ended with the given player on top
    task automatic expect_end(input cell_t who);
        a_end_over: assert (game_over === 1'b1)
            else mismatch("game_over", game_over, 1'b1);
        a_end_winner: assert (winner === who)
            else mismatch("winner", winner, who);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        $display("Test %s: %0d errors", name, errors - errs_before);
    endtask

    initial
    begin
        logic b0;
        logic b1;
        int   start;
        clk        = 1'b0;
        rst_n      = 1'b0;
        move_right = 1'b1;
        move_left  = 1'b1;
        drop_piece = 1'b1;
        settle     = 1'b0;
        lfsr       = 16'd14377;
        errors     = 0;
        cycles     = 0;

        start = errors;
        reset_dut();
        finish_test("reset state", start);

        start = errors;
        for (int i = 0; i < 20; i++)
        begin
            random_bit(b0);
            random_bit(b1);
            case ({b1, b0})
                2'd1:    push(1'b0, 1'b1, 1'b0);
                2'd2:    push(1'b1, 1'b1, 1'b0);
                default: push(1'b1, 1'b0, 1'b0);
            endcase
        end
        finish_test("cursor moves", start);

        start = errors;
        drop_at(2);
        drop_at(2);
        drop_at(2);
        drop_at(5);
        drop_at(5);
        finish_test("alternating drops", start);

        start = errors;
        for (int i = 0; i <= ROWS; i++)
        begin
            drop_at(0);
        end
        finish_test("full column", start);

        start = errors;
        reset_dut();
        for (int i = 0; i < 7; i++)
        begin
            drop_at(i % 2);
        end
        expect_end(PLAYER1);
        push(1'b1, 1'b0, 1'b0);
        push(1'b0, 1'b1, 1'b0);
        push(1'b0, 1'b0, 1'b1);
        finish_test("vertical win", start);

        start = errors;
        reset_dut();
        // P2 diagonal (0,0) to (3,3), closed at (2,2)
        drop_at(1);
        drop_at(0);
        drop_at(2);
        drop_at(1);
        drop_at(3);
        drop_at(2);
        drop_at(3);
        drop_at(3);
        drop_at(6);
        drop_at(3);
        drop_at(6);
        drop_at(2);
        expect_end(PLAYER2);
        reset_dut();
        for (int i = 0; i < 7; i++)
        begin
            drop_at(i / 2);
        end
        expect_end(PLAYER1);
        finish_test("diagonal and row wins", start);

        $display("Tests run: 6, errors: %0d", errors);
        if (errors == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/connect_four.sv
`timescale 1ns/1ns
`default_nettype none

module connect_four
#(
    parameter int ROWS = 8,
    parameter int COLS = 8
)
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    move_right,
    input  logic                    move_left,
    input  logic                    drop_piece,
    output c4_pkg::cell_t           board_out [0:ROWS-1][0:COLS-1],
    output logic [$clog2(COLS)-1:0] current_col,
    output c4_pkg::cell_t           current_player,
    output logic                    game_over,
    output c4_pkg::cell_t           winner
);

    logic move_right_press;
    logic move_left_press;
    logic drop_press;
    logic check_done;
    logic check_win;

    drop_if #(.ROWS(ROWS), .COLS(COLS)) drp ();

    button_sync i_sync_right (.clk(clk), .rst_n(rst_n), .btn(move_right), .press(move_right_press));
    button_sync i_sync_left  (.clk(clk), .rst_n(rst_n), .btn(move_left),  .press(move_left_press));
    button_sync i_sync_drop  (.clk(clk), .rst_n(rst_n), .btn(drop_piece), .press(drop_press));

    game_control #(.ROWS(ROWS), .COLS(COLS)) i_game_control
    (
        .clk              (clk),
        .rst_n            (rst_n),
        .move_right_press (move_right_press),
        .move_left_press  (move_left_press),
        .drop_press       (drop_press),
        .check_done       (check_done),
        .check_win        (check_win),
        .current_col      (current_col),
        .current_player   (current_player),
        .game_over        (game_over),
        .winner           (winner),
        .drp              (drp.ctrl)
    );

    board_store #(.ROWS(ROWS), .COLS(COLS)) i_board_store
    (
        .clk   (clk),
        .rst_n (rst_n),
        .drp   (drp.sink),
        .board (board_out)
    );

    win_checker #(.ROWS(ROWS), .COLS(COLS)) i_win_checker
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .drp        (drp.sink),
        .board      (board_out),
        .check_done (check_done),
        .check_win  (check_win)
    );

endmodule

`default_nettype wire

//--- hdl/win_checker.sv
`timescale 1ns/1ns
`default_nettype none

module win_checker
#(
    parameter int ROWS = 8,
    parameter int COLS = 8
)
(
    input  logic          clk,
    input  logic          rst_n,
    drop_if.sink          drp,
    input  c4_pkg::cell_t board [0:ROWS-1][0:COLS-1],
    output logic          check_done,
    output logic          check_win
);

    import c4_pkg::*;

    localparam int ROW_W = $clog2(ROWS);
    localparam int COL_W = $clog2(COLS);

    logic [ROW_W-1:0] row_q;
    logic [COL_W-1:0] col_q;
    cell_t            player_q;
    scan_win_t        step;
    logic             busy;
    logic             win_flag;
    logic             match;

    // Position of the new piece, held for the whole scan
    always_ff @(posedge clk)
    begin
        if (drp.place)
        begin
            row_q    <= drp.row;
            col_q    <= drp.col;
            player_q <= drp.player;
        end
    end

    // Window for this step, k is the new piece's offset inside it
    always_comb
    begin
        int dr;
        int dc;
        int k;
        int r0;
        int c0;
        int r3;
        int c3;
        logic fits;

        if (step == DOWN)
        begin
            dr = 1;
            dc = 0;
            k  = WIN_LEN - 1;
        end
        else if (step <= ROW_4)
        begin
            dr = 0;
            dc = 1;
            k  = int'(ROW_4) - int'(step);
        end
        else if (step <= DIAG_UP_4)
        begin
            dr = 1;
            dc = 1;
            k  = int'(DIAG_UP_4) - int'(step);
        end
        else
        begin
            dr = -1;
            dc = 1;
            k  = int'(DIAG_DOWN_4) - int'(step);
        end

        r0 = int'(row_q) - k * dr;
        c0 = int'(col_q) - k * dc;
        r3 = r0 + (WIN_LEN - 1) * dr;
        c3 = c0 + (WIN_LEN - 1) * dc;
        fits = (r0 >= 0) && (r0 < ROWS) && (r3 >= 0) && (r3 < ROWS) &&
               (c0 >= 0) && (c3 < COLS);

        match = fits;
        if (fits)
        begin
            for (int i = 0; i < WIN_LEN; i++)
            begin
                if (board[r0 + i * dr][c0 + i * dc] != player_q)
                begin
                    match = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy       <= 1'b0;
            step       <= DOWN;
            win_flag   <= 1'b0;
            check_done <= 1'b0;
        end
        else
        begin
            check_done <= 1'b0;
            if (drp.place)
            begin
                busy     <= 1'b1;
                step     <= DOWN;
                win_flag <= 1'b0;
            end
            else if (busy)
            begin
                win_flag <= win_flag | match;
                if (step == DIAG_DOWN_4)
                begin
                    busy       <= 1'b0;
                    check_done <= 1'b1;
                end
                else
                begin
                    step <= scan_win_t'(step + 1'b1);
                end
            end
        end
    end

    // Flag already holds the last window when done fires
    assign check_win = win_flag;

    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        check_done |=> !check_done);

endmodule

`default_nettype wire

//--- hdl/board_store.sv
`timescale 1ns/1ns
`default_nettype none

module board_store
#(
    parameter int ROWS = 8,
    parameter int COLS = 8
)
(
    input  logic          clk,
    input  logic          rst_n,
    drop_if.sink          drp,
    output c4_pkg::cell_t board [0:ROWS-1][0:COLS-1]
);

    import c4_pkg::*;

    // Row 0 is the bottom of the board
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int r = 0; r < ROWS; r++)
            begin
                for (int c = 0; c < COLS; c++)
                begin
                    board[r][c] <= EMPTY;
                end
            end
        end
        else if (drp.place)
        begin
            board[drp.row][drp.col] <= drp.player;
        end
    end

    // Controller heights must agree with what is stored
    a_place_on_empty: assert property (@(posedge clk) disable iff (!rst_n)
        drp.place |-> board[drp.row][drp.col] == EMPTY);

endmodule

`default_nettype wire

//--- hdl/game_control.sv
`timescale 1ns/1ns
`default_nettype none

module game_control
#(
    parameter int ROWS = 8,
    parameter int COLS = 8
)
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    move_right_press,
    input  logic                    move_left_press,
    input  logic                    drop_press,
    input  logic                    check_done,
    input  logic                    check_win,
    output logic [$clog2(COLS)-1:0] current_col,
    output c4_pkg::cell_t           current_player,
    output logic                    game_over,
    output c4_pkg::cell_t           winner,
    drop_if.ctrl                    drp
);

    import c4_pkg::*;

    localparam int ROW_W = $clog2(ROWS);
    localparam int COL_W = $clog2(COLS);

    game_state_t      state;
    logic [ROW_W:0]   heights [0:COLS-1];
    logic [ROW_W:0]   cur_height;
    logic             col_free;
    logic [COL_W-1:0] next_col_right;
    logic [COL_W-1:0] next_col_left;
    cell_t            next_player;

    if (ROWS < WIN_LEN || COLS < WIN_LEN)
    begin : g_size_check
        $error("Board is smaller than the winning run");
    end

    assign cur_height = heights[current_col];
    assign col_free   = int'(cur_height) < ROWS;

    assign next_col_right = (current_col == COL_W'(COLS - 1)) ? '0 : current_col + 1'b1;
    assign next_col_left  = (current_col == '0) ? COL_W'(COLS - 1) : current_col - 1'b1;
    assign next_player    = (current_player == PLAYER1) ? PLAYER2 : PLAYER1;

    // Placement goes out in the single ADDING cycle
    assign drp.place  = (state == ST_ADDING_PIECE) && col_free;
    assign drp.row    = cur_height[ROW_W-1:0];
    assign drp.col    = current_col;
    assign drp.player = current_player;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state          <= ST_IDLE;
            current_col    <= '0;
            current_player <= PLAYER1;
            game_over      <= 1'b0;
            winner         <= EMPTY;
            for (int c = 0; c < COLS; c++)
            begin
                heights[c] <= '0;
            end
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    // Both cursor buttons together cancel out
                    if (move_right_press && !move_left_press)
                    begin
                        current_col <= next_col_right;
                    end
                    else if (move_left_press && !move_right_press)
                    begin
                        current_col <= next_col_left;
                    end
                    if (drop_press)
                    begin
                        state <= ST_ADDING_PIECE;
                    end
                end
                ST_ADDING_PIECE:
                begin
                    state <= col_free ? ST_CHECKING : ST_IDLE;
                end
                ST_CHECKING:
                begin
                    if (check_done && check_win)
                    begin
                        game_over <= 1'b1;
                        winner    <= current_player;
                        state     <= ST_WIN;
                    end
                    else if (check_done)
                    begin
                        heights[current_col] <= cur_height + 1'b1;
                        current_player       <= next_player;
                        state                <= ST_IDLE;
                    end
                end
                default:
                begin
                    state <= ST_WIN;
                end
            endcase
        end
    end

    // Checker result only arrives while the controller waits for it
    a_done_in_checking: assert property (@(posedge clk) disable iff (!rst_n)
        check_done |-> state == ST_CHECKING);

    a_game_over_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        game_over |=> game_over);

endmodule

`default_nettype wire

//--- hdl/button_sync.sv
`timescale 1ns/1ns
`default_nettype none

module button_sync
(
    input  logic clk,
    input  logic rst_n,
    input  logic btn,
    output logic press
);

    logic [2:0] sync;

    // Button is active low, idle level is high
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sync <= 3'b111;
        end
        else
        begin
            sync <= {sync[1:0], btn};
        end
    end

    // Falling edge between the two older stages
    assign press = sync[2] & ~sync[1];

endmodule

`default_nettype wire

//--- hdl/drop_if.sv
`timescale 1ns/1ns
`default_nettype none

interface drop_if
#(
    parameter int ROWS = 8,
    parameter int COLS = 8
);
    import c4_pkg::*;

    logic                      place;
    logic [$clog2(ROWS)-1:0]   row;
    logic [$clog2(COLS)-1:0]   col;
    cell_t                     player;

    modport ctrl (output place, output row, output col, output player);
    modport sink (input place, input row, input col, input player);

endinterface

`default_nettype wire

//--- hdl/c4_pkg.sv
`default_nettype none

package c4_pkg;

    // One board square, also used to name a player
    typedef enum logic [1:0]
    {
        EMPTY   = 2'b00,
        PLAYER1 = 2'b01,
        PLAYER2 = 2'b10
    } cell_t;

    typedef enum logic [1:0]
    {
        ST_IDLE         = 2'b00,
        ST_ADDING_PIECE = 2'b01,
        ST_CHECKING     = 2'b10,
        ST_WIN          = 2'b11
    } game_state_t;

    // Scan order of the windows through the last piece
    typedef enum logic [3:0]
    {
        DOWN,
        ROW_1, ROW_2, ROW_3, ROW_4,
        DIAG_UP_1, DIAG_UP_2, DIAG_UP_3, DIAG_UP_4,
        DIAG_DOWN_1, DIAG_DOWN_2, DIAG_DOWN_3, DIAG_DOWN_4
    } scan_win_t;

    localparam int WIN_LEN = 4;

endpackage

`default_nettype wire
